// File: hdl/fetch_defines.svh
// ##########################################################################
// constants for the fetch front end; the reset vector is a fixed cs:ip pair
// and the queue depth must be a power of two of at least 2
// ##########################################################################
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

`define RESET_CS    16'h1000    // code segment after reset
`define RESET_IP    16'h0100    // instruction pointer after reset
`define PADDR_W     20          // cs*16 + ip
`define QUEUE_DEPTH 4

// segment override prefixes
`define PFX_ES      8'h26
`define PFX_CS      8'h2E
`define PFX_SS      8'h36
`define PFX_DS      8'h3E

// rep prefixes
`define PFX_REPNZ   8'hF2
`define PFX_REPZ    8'hF3

`define OP_NOP      8'h90

`endif

// File: hdl/fetch_pkg.sv
// ##########################################################################
// shared types; byte-wide APB reads only, no pslverr and no write data
// ##########################################################################
`include "fetch_defines.svh"

package fetch_pkg;

  typedef struct packed {
    logic [`PADDR_W-1:0] paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;    // always 0 here
  } apb_req_t;

  typedef struct packed {
    logic [7:0] prdata;
    logic       pready;
  } apb_rsp_t;

  // fsm to bus master
  typedef struct packed {
    logic                valid;
    logic [`PADDR_W-1:0] addr;
  } byte_req_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_rsp_t;

  // length decode of one opcode/modrm pair
  typedef struct packed {
    logic       need_modrm;
    logic [1:0] off_len;     // bytes, 0..2
    logic [1:0] imm_len;     // bytes, 0..2
    logic       illegal;
    logic       is_prefix;
  } decode_t;

  typedef struct packed {
    logic [`PADDR_W-1:0] pc;         // first byte, prefixes included
    logic                rep_valid;
    logic                rep_z;
    logic                seg_valid;
    logic [1:0]          seg;        // es, cs, ss, ds
    logic [7:0]          opcode;
    logic [7:0]          modrm;
    logic [15:0]         off;
    logic [15:0]         imm;
    logic [3:0]          len;
    logic                illegal;
  } instr_t;

endpackage

// File: hdl/code_bus_master.sv
// ##########################################################################
// one APB read per byte request; a request is only taken when idle and
// the completer must not signal an error (there is no pslverr)
// ##########################################################################
`timescale 1ns/100ps
`include "fetch_defines.svh"

module code_bus_master (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::byte_req_t req,
  output fetch_pkg::byte_rsp_t rsp,
  output fetch_pkg::apb_req_t  apb_req,
  input  fetch_pkg::apb_rsp_t  apb_rsp
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SETUP,
    S_ACCESS
  } bus_state_t;

  bus_state_t          state;
  logic [`PADDR_W-1:0] addr_q;
  logic [7:0]          data_q;
  logic                rsp_valid_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= S_IDLE;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      rsp_valid_q <= 1'b0;   // single-cycle strobe
      case (state)
        S_IDLE:
          if (req.valid)
          begin
            addr_q <= req.addr;
            state  <= S_SETUP;
          end
        S_SETUP:
          state <= S_ACCESS;
        S_ACCESS:
          if (apb_rsp.pready)
          begin
            data_q      <= apb_rsp.prdata;
            rsp_valid_q <= 1'b1;
            state       <= S_IDLE;   // psel drops for at least a cycle
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // paddr held from setup to completion
  assign apb_req = '{
    paddr:   addr_q,
    psel:    (state != S_IDLE),
    penable: (state == S_ACCESS),
    pwrite:  1'b0
  };

  assign rsp = '{valid: rsp_valid_q, data: data_q};

endmodule

// File: hdl/opcode_decode.sv
// ##########################################################################
// length decode for the supported opcode subset only; anything outside
// the table is flagged illegal with no trailing bytes
// ##########################################################################
`timescale 1ns/100ps
`include "fetch_defines.svh"

module opcode_decode (
  input  logic [7:0]         opcode,
  input  logic [7:0]         modrm,
  output fetch_pkg::decode_t dec
);

  logic [1:0] mod_bits;
  logic [2:0] rm_bits;
  logic [1:0] modrm_off_len;

  assign mod_bits = modrm[7:6];
  assign rm_bits  = modrm[2:0];

  // displacement size from the mod field
  always_comb
  begin
    case (mod_bits)
      2'b00:   modrm_off_len = (rm_bits == 3'b110) ? 2'd2 : 2'd0;  // direct address
      2'b01:   modrm_off_len = 2'd1;
      2'b10:   modrm_off_len = 2'd2;
      default: modrm_off_len = 2'd0;   // register operand
    endcase
  end

  always_comb
  begin
    dec = '0;
    case (opcode) inside
      `PFX_ES, `PFX_CS, `PFX_SS, `PFX_DS, `PFX_REPNZ, `PFX_REPZ:
        dec.is_prefix = 1'b1;
      `OP_NOP:
        dec = '0;      // single byte
      [8'h88:8'h8B]:
        dec.need_modrm = 1'b1;   // mov r/m
      [8'hA0:8'hA3]:
        dec.off_len = 2'd2;      // mov acc, moffs
      [8'hB0:8'hB7]:
        dec.imm_len = 2'd1;
      [8'hB8:8'hBF]:
        dec.imm_len = 2'd2;
      8'h04:
        dec.imm_len = 2'd1;
      8'h05:
        dec.imm_len = 2'd2;
      8'h80, 8'h83:
      begin
        dec.need_modrm = 1'b1;
        dec.imm_len    = 2'd1;
      end
      8'h81:
      begin
        dec.need_modrm = 1'b1;
        dec.imm_len    = 2'd2;
      end
      default:
        dec.illegal = 1'b1;
    endcase

    if (dec.need_modrm)
      dec.off_len = modrm_off_len;
  end

endmodule

// File: hdl/fetch_fsm.sv
// ##########################################################################
// byte-serial length decoder, one byte outstanding at a time; ip only
// moves forward and wraps in its segment, len is 4 bits (at most 15 bytes)
// ##########################################################################
`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetch_fsm (
  input  logic                 clk,
  input  logic                 rst,
  output fetch_pkg::byte_req_t byte_req,
  input  fetch_pkg::byte_rsp_t byte_rsp,
  output logic                 push,
  output fetch_pkg::instr_t    instr,
  input  logic                 not_full
);
  import fetch_pkg::*;

  typedef enum logic [2:0] {
    S_OPCODE,
    S_MODRM,
    S_OFFSET,
    S_IMM,
    S_EMIT
  } fsm_state_t;

  fsm_state_t          state;
  fsm_state_t          state_n;
  instr_t              rec;
  instr_t              rec_n;
  decode_t             dec;
  logic [7:0]          dec_opcode;
  logic [7:0]          dec_modrm;
  logic [15:0]         cs;
  logic [15:0]         ip;
  logic [15:0]         ip_n;
  logic [`PADDR_W-1:0] seg_base;
  logic [`PADDR_W-1:0] byte_addr;
  logic                cnt;
  logic                cnt_n;
  logic                pending;
  logic                issue;

  // first field after the modrm, or after an opcode without one
  function automatic fsm_state_t next_field(decode_t d);
    if (d.off_len != 2'd0)
      return S_OFFSET;
    if (d.imm_len != 2'd0)
      return S_IMM;
    return S_EMIT;
  endfunction

  // incoming byte feeds the decoder directly
  assign dec_opcode = (state == S_OPCODE) ? byte_rsp.data : rec.opcode;
  assign dec_modrm  = (state == S_MODRM) ? byte_rsp.data : rec.modrm;

  opcode_decode u_decode (
    .opcode (dec_opcode),
    .modrm  (dec_modrm),
    .dec    (dec)
  );

  assign seg_base  = {cs, 4'h0};
  assign byte_addr = seg_base + {4'h0, ip};        // byte now answered
  assign ip_n      = ip + {15'd0, byte_rsp.valid};

  always_comb
  begin
    state_n = state;
    rec_n   = rec;
    cnt_n   = cnt;
    case (state)
      S_OPCODE:
        if (byte_rsp.valid)
        begin
          rec_n.len = rec.len + 4'd1;
          if (rec.len == 4'd0)
            rec_n.pc = byte_addr;
          if (dec.is_prefix)
          begin
            if (byte_rsp.data == `PFX_REPNZ || byte_rsp.data == `PFX_REPZ)
            begin
              rec_n.rep_valid = 1'b1;
              rec_n.rep_z     = (byte_rsp.data == `PFX_REPZ);
            end
            else
            begin
              rec_n.seg_valid = 1'b1;
              rec_n.seg       = byte_rsp.data[4:3];   // 26/2e/36/3e
            end
          end
          else
          begin
            rec_n.opcode  = byte_rsp.data;
            rec_n.illegal = dec.illegal;
            state_n = dec.need_modrm ? S_MODRM : next_field(dec);
          end
        end
      S_MODRM:
        if (byte_rsp.valid)
        begin
          rec_n.len   = rec.len + 4'd1;
          rec_n.modrm = byte_rsp.data;
          state_n     = next_field(dec);
        end
      S_OFFSET:
        if (byte_rsp.valid)
        begin
          rec_n.len = rec.len + 4'd1;
          if (cnt)
            rec_n.off[15:8] = byte_rsp.data;
          else
            rec_n.off[7:0] = byte_rsp.data;
          if (cnt || dec.off_len == 2'd1)
          begin
            cnt_n   = 1'b0;
            state_n = (dec.imm_len != 2'd0) ? S_IMM : S_EMIT;
          end
          else
            cnt_n = 1'b1;
        end
      S_IMM:
        if (byte_rsp.valid)
        begin
          rec_n.len = rec.len + 4'd1;
          if (cnt)
            rec_n.imm[15:8] = byte_rsp.data;
          else
            rec_n.imm[7:0] = byte_rsp.data;
          if (cnt || dec.imm_len == 2'd1)
          begin
            cnt_n   = 1'b0;
            state_n = S_EMIT;
          end
          else
            cnt_n = 1'b1;
        end
      S_EMIT:
        if (not_full)
        begin
          rec_n   = '0;      // prefix latches clear here too
          state_n = S_OPCODE;
        end
      default:
        state_n = S_OPCODE;
    endcase
  end

  // next byte goes out in the same cycle the previous one returns
  assign issue = (state_n != S_EMIT) && (!pending || byte_rsp.valid);

  assign byte_req = '{valid: issue, addr: seg_base + {4'h0, ip_n}};
  assign push     = (state == S_EMIT) && not_full;
  assign instr    = rec;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= S_OPCODE;
      rec     <= '0;
      cnt     <= 1'b0;
      pending <= 1'b0;
      cs      <= `RESET_CS;
      ip      <= `RESET_IP;
    end
    else
    begin
      state   <= state_n;
      rec     <= rec_n;
      cnt     <= cnt_n;
      pending <= issue || (pending && !byte_rsp.valid);
      ip      <= ip_n;     // wraps at 64 KiB
    end
  end

endmodule

// File: hdl/instr_queue.sv
// ##########################################################################
// first-word-fall-through FIFO; DEPTH must be a power of two >= 2 and a
// push while full is dropped, so the writer has to watch not_full
// ##########################################################################
`timescale 1ns/100ps
`include "fetch_defines.svh"

module instr_queue #(
  parameter int DEPTH = `QUEUE_DEPTH
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  fetch_pkg::instr_t din,
  output logic              not_full,
  output logic              instr_valid,
  input  logic              instr_ready,
  output fetch_pkg::instr_t dout
);
  import fetch_pkg::*;

  localparam int AW = $clog2(DEPTH);

  instr_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          wr_en;
  logic          pop;

  assign wr_en       = push && not_full;
  assign pop         = instr_valid && instr_ready;
  assign not_full    = (count != (AW + 1)'(DEPTH));
  assign instr_valid = (count != '0);
  assign dout        = mem[rd_ptr];   // head is always on the output

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/fetch_top.sv
// ##########################################################################
// fetch front end top; code memory is an external APB completer
// ##########################################################################
`timescale 1ns/100ps

module fetch_top (
  input  logic                clk,
  input  logic                rst,
  output fetch_pkg::apb_req_t apb_req,
  input  fetch_pkg::apb_rsp_t apb_rsp,
  output logic                instr_valid,
  input  logic                instr_ready,
  output fetch_pkg::instr_t   instr
);
  import fetch_pkg::*;

  byte_req_t bus_req;
  byte_rsp_t bus_rsp;
  instr_t    fsm_instr;
  logic      push;
  logic      not_full;

  code_bus_master u_bus (
    .clk     (clk),
    .rst     (rst),
    .req     (bus_req),
    .rsp     (bus_rsp),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  fetch_fsm u_fsm (
    .clk      (clk),
    .rst      (rst),
    .byte_req (bus_req),
    .byte_rsp (bus_rsp),
    .push     (push),
    .instr    (fsm_instr),
    .not_full (not_full)
  );

  instr_queue u_queue (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .din         (fsm_instr),
    .not_full    (not_full),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .dout        (instr)
  );

endmodule

// File: tb/code_memory_model.sv
// ##########################################################################
// APB completer for the code memory; 64 KiB of bytes indexed by the low
// 16 address bits, read only, 0 to 2 random wait states per transfer
// ##########################################################################
`timescale 1ns/100ps

module code_memory_model (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::apb_req_t apb_req,
  output fetch_pkg::apb_rsp_t apb_rsp
);
  import fetch_pkg::*;

  logic [7:0] mem [0:65535];   // loaded by the testbench
  logic [1:0] wait_cnt;
  logic       setup;
  logic       access;

  assign setup  = apb_req.psel && !apb_req.penable;
  assign access = apb_req.psel && apb_req.penable;

  // wait states picked in the setup phase
  always_ff @(posedge clk)
  begin
    if (rst)
      wait_cnt <= 2'd0;
    else if (setup)
      wait_cnt <= 2'($urandom_range(2, 0));
    else if (access && wait_cnt != 2'd0)
      wait_cnt <= wait_cnt - 2'd1;
  end

  assign apb_rsp = '{
    prdata: mem[apb_req.paddr[15:0]],
    pready: access && (wait_cnt == 2'd0)
  };

endmodule

// File: tb/tb_fetch_top.sv
// ##########################################################################
// random program of supported and illegal opcodes at the reset vector;
// the program must stay inside the code segment, no ip wrap is exercised
// ##########################################################################
`timescale 1ns/100ps
`include "fetch_defines.svh"

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int N_INSTR = 60;

  logic     clk;
  logic     rst;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     instr_valid;
  logic     instr_ready;
  instr_t   instr;

  instr_t      exp_q[$];
  int          n_total;
  logic [15:0] gen_ip;
  int          stall_left;

  // checker state
  logic                after_reset;
  logic                prev_setup;
  logic                prev_wait;
  logic                prev_done;
  logic                prev_stall;
  logic [`PADDR_W-1:0] prev_paddr;
  instr_t              prev_instr;
  logic [`PADDR_W-1:0] last_pc;
  logic [3:0]          last_len;
  logic [15:0]         exp_ip;
  int                  n_rx;

  fetch_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr)
  );

  code_memory_model u_mem (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #10 clk = ~clk;

  task automatic fail_text(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [79:0] expv,
                            input logic [79:0] actv);
    fail_text($sformatf("FAIL %s expected %h actual %h", name, expv, actv));
  endtask

  function automatic logic [7:0] prefix_byte(input int i);
    case (i)
      0:       return 8'h26;
      1:       return 8'h2E;
      2:       return 8'h36;
      3:       return 8'h3E;
      4:       return 8'hF2;
      default: return 8'hF3;
    endcase
  endfunction

  // opcodes outside the supported table
  function automatic logic [7:0] illegal_byte(input int i);
    case (i)
      0:       return 8'h00;
      1:       return 8'h0F;
      2:       return 8'hC3;
      3:       return 8'hCC;
      default: return 8'hF4;
    endcase
  endfunction

  task automatic write_code_byte(input logic [7:0] b);
    logic [`PADDR_W-1:0] a;
    a = {`RESET_CS, 4'h0} + {4'h0, gen_ip};
    u_mem.mem[a[15:0]] = b;
    gen_ip = gen_ip + 16'd1;
  endtask

  task automatic add_random_instr;
    instr_t     r;
    int         n_pfx;
    int         kind;
    int         off_len;
    int         imm_len;
    logic       need_modrm;
    logic [7:0] b;
    logic [7:0] op;
    r          = '0;
    off_len    = 0;
    imm_len    = 0;
    need_modrm = 1'b0;
    r.pc       = {`RESET_CS, 4'h0} + {4'h0, gen_ip};
    n_pfx      = ($urandom_range(5, 0) == 0) ? int'($urandom_range(2, 1)) : 0;
    for (int i = 0; i < n_pfx; i++)
    begin
      b = prefix_byte(int'($urandom_range(5, 0)));
      write_code_byte(b);
      r.len = r.len + 4'd1;
      if (b == 8'hF2 || b == 8'hF3)
      begin
        r.rep_valid = 1'b1;
        r.rep_z     = (b == 8'hF3);
      end
      else
      begin
        r.seg_valid = 1'b1;
        r.seg = (b == 8'h26) ? 2'd0 : (b == 8'h2E) ? 2'd1 : (b == 8'h36) ? 2'd2 : 2'd3;
      end
    end
    kind = int'($urandom_range(10, 0));
    case (kind)
      0: op = 8'h90;
      1, 10:
      begin
        op         = 8'h88 + 8'($urandom_range(3, 0));
        need_modrm = 1'b1;
      end
      2:
      begin
        op      = 8'hA0 + 8'($urandom_range(3, 0));
        off_len = 2;
      end
      3:
      begin
        op      = 8'hB0 + 8'($urandom_range(7, 0));
        imm_len = 1;
      end
      4:
      begin
        op      = 8'hB8 + 8'($urandom_range(7, 0));
        imm_len = 2;
      end
      5:
      begin
        op      = 8'h04;
        imm_len = 1;
      end
      6:
      begin
        op      = 8'h05;
        imm_len = 2;
      end
      7:
      begin
        op         = ($urandom_range(1, 0) == 0) ? 8'h80 : 8'h83;
        need_modrm = 1'b1;
        imm_len    = 1;
      end
      8:
      begin
        op         = 8'h81;
        need_modrm = 1'b1;
        imm_len    = 2;
      end
      default:
      begin
        op        = illegal_byte(int'($urandom_range(4, 0)));
        r.illegal = 1'b1;
      end
    endcase
    write_code_byte(op);
    r.opcode = op;
    r.len    = r.len + 4'd1;
    if (need_modrm)
    begin
      b = 8'($urandom);
      write_code_byte(b);
      r.modrm = b;
      r.len   = r.len + 4'd1;
      case (b[7:6])   // displacement from mod and rm
        2'b00:   off_len = (b[2:0] == 3'b110) ? 2 : 0;
        2'b01:   off_len = 1;
        2'b10:   off_len = 2;
        default: off_len = 0;
      endcase
    end
    for (int k = 0; k < off_len; k++)
    begin
      b = 8'($urandom);
      write_code_byte(b);
      r.off[8*k +: 8] = b;   // little-endian
      r.len = r.len + 4'd1;
    end
    for (int k = 0; k < imm_len; k++)
    begin
      b = 8'($urandom);
      write_code_byte(b);
      r.imm[8*k +: 8] = b;
      r.len = r.len + 4'd1;
    end
    exp_q.push_back(r);
  endtask

  initial
  begin
    logic [15:0] a;
    void'($urandom(894));
    clk         = 1'b0;
    rst         = 1'b1;
    instr_ready = 1'b0;
    stall_left  = 0;
    for (int i = 0; i < 65536; i++)
    begin
      a = 16'(i);
      u_mem.mem[i] = a[15:8] ^ a[7:0] ^ 8'h5A;   // background past the program
    end
    gen_ip = `RESET_IP;
    for (int i = 0; i < N_INSTR; i++)
      add_random_instr();
    n_total = exp_q.size();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

  // ready with long low stretches, long enough to fill the queue
  always @(posedge clk)
  begin
    if (stall_left > 0)
    begin
      instr_ready <= 1'b0;
      stall_left  <= stall_left - 1;
    end
    else if ($urandom_range(7, 0) == 0)
    begin
      instr_ready <= 1'b0;
      stall_left  <= int'($urandom_range(80, 20));
    end
    else
      instr_ready <= ($urandom_range(3, 0) != 0);
  end

  initial
  begin
    #(N_INSTR * 8 * 6 * 20 + 20000);
    fail_text("watchdog expired before all instruction records arrived");
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      after_reset = 1'b1;
      prev_setup  = 1'b0;
      prev_wait   = 1'b0;
      prev_done   = 1'b0;
      prev_stall  = 1'b0;
      exp_ip      = `RESET_IP;
      n_rx        = 0;
    end
    else
    begin
      if (after_reset)
      begin
        assert (!apb_req.psel && !apb_req.penable && !instr_valid)
          else fail_text("psel, penable or instr_valid high right after reset");
        after_reset = 1'b0;
      end
      assert (!apb_req.pwrite)
        else fail_value("apb_req.pwrite", 80'h0, 80'(apb_req.pwrite));
      assert (!apb_req.penable || apb_req.psel)
        else fail_text("penable high without psel");
      if (apb_req.penable)
        assert (prev_setup || prev_wait)
          else fail_text("penable high without a setup phase before it");
      if (prev_done)
        assert (!apb_req.psel) else fail_text("psel did not drop between transfers");
      if (prev_setup || prev_wait)
      begin
        assert (apb_req.psel && apb_req.penable)
          else fail_text("access phase missing or ended before pready");
        assert (apb_req.paddr == prev_paddr)
          else fail_value("apb_req.paddr", 80'(prev_paddr), 80'(apb_req.paddr));
      end
      if (apb_req.psel && !apb_req.penable)
      begin
        assert (apb_req.paddr == {`RESET_CS, 4'h0} + {4'h0, exp_ip})
          else fail_value("apb_req.paddr", 80'({`RESET_CS, 4'h0} + {4'h0, exp_ip}),
                          80'(apb_req.paddr));
        exp_ip = exp_ip + 16'd1;   // stays inside the segment
      end
      if (prev_stall)
      begin
        assert (instr_valid) else fail_text("instr_valid dropped while instr_ready low");
        assert (instr == prev_instr)
          else fail_value("instr", 80'(prev_instr), 80'(instr));
      end
      if (instr_valid && instr_ready)
      begin
        assert (exp_q.size() != 0) else fail_text("record received beyond the program");
        if (n_rx > 0)
          assert (instr.pc == last_pc + {16'd0, last_len})
            else fail_value("instr.pc", 80'(last_pc + {16'd0, last_len}), 80'(instr.pc));
        assert (instr == exp_q[0]) else fail_value("instr", 80'(exp_q[0]), 80'(instr));
        void'(exp_q.pop_front());
        last_pc  = instr.pc;
        last_len = instr.len;
        n_rx     = n_rx + 1;
        if (n_rx == n_total)
        begin
          $display("All tests passed!");
          $finish;
        end
      end
      prev_setup = apb_req.psel && !apb_req.penable;
      prev_wait  = apb_req.penable && !apb_rsp.pready;
      prev_done  = apb_req.penable && apb_rsp.pready;
      prev_paddr = apb_req.paddr;
      prev_stall = instr_valid && !instr_ready;
      prev_instr = instr;
    end
  end

endmodule

// File: src.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/code_bus_master.sv
hdl/opcode_decode.sv
hdl/fetch_fsm.sv
hdl/instr_queue.sv
hdl/fetch_top.sv
tb/code_memory_model.sv
tb/tb_fetch_top.sv

// File: run.sh
#!/bin/sh
# builds the fetch front end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module tb_fetch_top -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "All tests passed!" sim.log
then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
